//--- dispatch.f
verilog/dispatch_pkg.sv
verilog/instr_decoder.sv
verilog/reg_status_table.sv
verilog/dispatch.sv
tb/dispatch_props.sv
tb/dispatch_tb.sv

//--- tb/dispatch_props.sv
module dispatch_props (
    input logic                     CLK,
    input logic                     nRST,
    input logic                     stall,
    input logic                     freeze,
    input logic                     flush,
    input logic                     s_en,
    input logic                     m_en,
    input logic                     g_en,
    input dispatch_pkg::rst_entry_t s_entry0
);

    import dispatch_pkg::*;

    logic any_en;

    assign any_en = s_en || m_en || g_en;

    one_enable: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0({s_en, m_en, g_en}))
        else $error("more than one FUST enable is set");

    stall_blocks_issue: assert property (@(posedge CLK) disable iff (!nRST)
        stall |-> !any_en)
        else $error("FUST enable raised while stall is set");

    hold_blocks_issue: assert property (@(posedge CLK) disable iff (!nRST)
        (freeze || flush) |-> !any_en)
        else $error("FUST enable raised during freeze or flush");

    // r0 has no producer
    r0_never_busy: assert property (@(posedge CLK) disable iff (!nRST)
        !s_entry0.busy && (s_entry0.tag == TAG_NONE))
        else $error("scalar register 0 is marked busy");

endmodule

//--- tb/dispatch_tb.sv
module dispatch_tb;

    import dispatch_pkg::*;

    localparam int N_INSTR    = 2000;
    localparam int MAX_CYCLES = 100000;

    logic       CLK;
    logic       nRST;
    fetch_t     fetch;
    logic       freeze;
    logic       flush;
    logic [2:0] fust_s_busy;
    logic       fust_m_busy;
    logic       fust_g_busy;
    wb_t        wb;
    dispatch_t  out;
    logic       stall;
    logic       n_fust_s_en;
    fu_s_e      n_fu_s;
    fust_s_t    n_fust_s;
    logic       n_fust_m_en;
    fust_m_t    n_fust_m;
    logic       n_fust_g_en;
    fust_g_t    n_fust_g;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          new_instr;
    int          cycles;
    int          i;
    logic        prev_hold;

    // reference tables, a register is pending when its tag is not TAG_NONE
    tag_t      s_tag [NUM_SREGS];
    tag_t      m_tag [NUM_MREGS];
    dispatch_t exp_out;

    // expectations for the inputs now applied
    ctrl_t     cur_ctrl;
    logic      exp_hazard;
    logic      exp_go;
    logic      exp_s_en;
    logic      exp_m_en;
    logic      exp_g_en;
    fust_s_t   exp_fust_s;
    fust_m_t   exp_fust_m;
    fust_g_t   exp_fust_g;
    dispatch_t exp_next;

    dispatch dut0 (
        .CLK         (CLK),
        .nRST        (nRST),
        .fetch       (fetch),
        .freeze      (freeze),
        .flush       (flush),
        .fust_s_busy (fust_s_busy),
        .fust_m_busy (fust_m_busy),
        .fust_g_busy (fust_g_busy),
        .wb          (wb),
        .out         (out),
        .stall       (stall),
        .n_fust_s_en (n_fust_s_en),
        .n_fu_s      (n_fu_s),
        .n_fust_s    (n_fust_s),
        .n_fust_m_en (n_fust_m_en),
        .n_fust_m    (n_fust_m),
        .n_fust_g_en (n_fust_g_en),
        .n_fust_g    (n_fust_g)
    );

    bind dispatch dispatch_props u_props (
        .CLK      (CLK),
        .nRST     (nRST),
        .stall    (stall),
        .freeze   (freeze),
        .flush    (flush),
        .s_en     (n_fust_s_en),
        .m_en     (n_fust_m_en),
        .g_en     (n_fust_g_en),
        .s_entry0 (s_status[0])
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [6:0] pick_opcode();
        logic [3:0] sel;
        sel = 4'(take_bits(4) % 9);
        case (sel)
            4'd0:    return OP_ALU_R;
            4'd1:    return OP_ALU_I;
            4'd2:    return OP_LOAD;
            4'd3:    return OP_STORE;
            4'd4:    return OP_BRANCH;
            4'd5:    return OP_M_LOAD;
            4'd6:    return OP_M_STORE;
            4'd7:    return OP_GEMM;
            default: return 7'b1111111;
        endcase
    endfunction

    // reference decode of the reduced ISA
    function automatic ctrl_t decode_ref(input logic [31:0] w);
        ctrl_t c;
        c = '0;
        case (w[6:0])
            OP_ALU_R: begin
                c.fu_t = FU_S_T;
                c.fu_s = FU_S_ALU;
                c.s_reg_write = 1'b1;
            end
            OP_ALU_I, OP_LOAD: begin
                c.fu_t = FU_S_T;
                c.fu_s = (w[6:0] == OP_LOAD) ? FU_S_LD_ST : FU_S_ALU;
                c.imm = w[31:20];
                c.s_mem_type = (w[6:0] == OP_LOAD) ? MEM_LOAD : MEM_NONE;
                c.s_reg_write = 1'b1;
            end
            OP_STORE: begin
                c.fu_t = FU_S_T;
                c.fu_s = FU_S_LD_ST;
                c.imm = {w[31:25], w[11:7]};
                c.s_mem_type = MEM_STORE;
            end
            OP_BRANCH: begin
                c.fu_t = FU_S_T;
                c.fu_s = FU_S_BRANCH;
                c.imm = {w[31], w[7], w[30:25], w[11:8]};
                c.branch_op = w[14:12];
            end
            OP_M_LOAD, OP_M_STORE: begin
                c.fu_t = FU_M_T;
                c.fu_m = FU_M_LD_ST;
                c.imm = {1'b0, w[27:25], w[14:7]};
                c.m_mem_type = (w[6:0] == OP_M_LOAD) ? MEM_LOAD : MEM_STORE;
                c.m_reg_write = (w[6:0] == OP_M_LOAD);
            end
            OP_GEMM: begin
                c.fu_t = FU_G_T;
                c.fu_m = FU_M_GEMM;
                c.m_reg_write = 1'b1;
            end
            default: c = '0;
        endcase
        if (c.fu_t != FU_NONE_T) begin
            c.alu_op = w[14:12];
        end
        return c;
    endfunction

    task automatic compute_expect();
        logic [31:0] w;
        logic        live;
        logic        unit_busy;
        logic        waw;
        w = fetch.imemload;
        cur_ctrl = decode_ref(w);
        live = fetch.valid && (cur_ctrl.fu_t != FU_NONE_T);
        case (cur_ctrl.fu_s)
            FU_S_ALU:    unit_busy = fust_s_busy[0];
            FU_S_LD_ST:  unit_busy = fust_s_busy[1];
            FU_S_BRANCH: unit_busy = fust_s_busy[2];
            default:     unit_busy = 1'b0;
        endcase
        if (cur_ctrl.fu_m == FU_M_LD_ST) begin
            unit_busy = fust_m_busy;
        end else if (cur_ctrl.fu_m == FU_M_GEMM) begin
            unit_busy = fust_g_busy;
        end
        waw = 1'b0;
        if (cur_ctrl.s_reg_write) begin
            waw = (s_tag[w[11:7]] != TAG_NONE);
        end else if (cur_ctrl.m_reg_write) begin
            waw = (m_tag[w[31:28]] != TAG_NONE);
        end
        exp_hazard = live && (unit_busy || waw);
        exp_go     = live && !exp_hazard && !freeze && !flush;
        exp_s_en   = exp_go && (cur_ctrl.fu_t == FU_S_T);
        exp_m_en   = exp_go && (cur_ctrl.fu_t == FU_M_T);
        exp_g_en   = exp_go && (cur_ctrl.fu_t == FU_G_T);

        exp_fust_s = {w[11:7], w[19:15], w[24:20], cur_ctrl.imm,
                      s_tag[w[19:15]], s_tag[w[24:20]]};
        exp_fust_m = {w[31:28], w[19:15], w[24:20], cur_ctrl.imm[10:0],
                      s_tag[w[19:15]], s_tag[w[24:20]]};
        exp_fust_g = {w[31:28], w[27:24], w[23:20], w[19:16],
                      m_tag[w[27:24]], m_tag[w[23:20]], m_tag[w[19:16]]};

        exp_next.valid             = live;
        exp_next.fu_s              = cur_ctrl.fu_s;
        exp_next.fu_m              = cur_ctrl.fu_m;
        exp_next.ex_ctr.imm        = cur_ctrl.imm;
        exp_next.ex_ctr.alu_op     = cur_ctrl.alu_op;
        exp_next.ex_ctr.branch_op  = cur_ctrl.branch_op;
        exp_next.ex_ctr.s_mem_type = cur_ctrl.s_mem_type;
        exp_next.ex_ctr.m_mem_type = cur_ctrl.m_mem_type;
        exp_next.ex_ctr.m_rw       = w[31:28];
        exp_next.ex_ctr.m_rw_en    = cur_ctrl.m_reg_write;
        exp_next.wb_ctr.s_rw_en    = cur_ctrl.s_reg_write;
        exp_next.wb_ctr.s_rw       = w[11:7];
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_outputs();
        compute_expect();
        check_value("stall", 64'(stall), 64'(exp_hazard));
        check_value("n_fust_s_en", 64'(n_fust_s_en), 64'(exp_s_en));
        check_value("n_fust_m_en", 64'(n_fust_m_en), 64'(exp_m_en));
        check_value("n_fust_g_en", 64'(n_fust_g_en), 64'(exp_g_en));
        check_value("n_fu_s", 64'(n_fu_s), 64'(cur_ctrl.fu_s));
        check_value("n_fust_s", 64'(n_fust_s), 64'(exp_fust_s));
        check_value("n_fust_m", 64'(n_fust_m), 64'(exp_fust_m));
        check_value("n_fust_g", 64'(n_fust_g), 64'(exp_fust_g));
        check_value("out", 64'(out), 64'(exp_out));
    endtask

    // upstream keeps the same word while stalled or frozen
    task automatic drive_inputs(input logic hold);
        logic [31:0] w;
        if (!hold) begin
            w = take_bits(32);
            w[6:0] = pick_opcode();
            fetch.imemload = w;
            fetch.valid    = (take_bits(3) != 0);
            new_instr++;
        end
        fust_s_busy[0] = (take_bits(3) == 0);
        fust_s_busy[1] = (take_bits(3) == 0);
        fust_s_busy[2] = (take_bits(3) == 0);
        fust_m_busy    = (take_bits(3) == 0);
        fust_g_busy    = (take_bits(3) == 0);
        freeze         = (take_bits(4) == 0);
        flush          = (take_bits(4) == 0);
        wb.s_rw_en     = 1'(take_bits(1));
        wb.s_rw        = 5'(take_bits(5));
        wb.m_rw_en     = 1'(take_bits(1));
        wb.m_rw        = 4'(take_bits(4));
    endtask

    // state after the coming rising edge, commit first so dispatch wins
    task automatic advance_model();
        logic [31:0] w;
        w = fetch.imemload;
        if (wb.s_rw_en) begin
            s_tag[wb.s_rw] = TAG_NONE;
        end
        if (wb.m_rw_en) begin
            m_tag[wb.m_rw] = TAG_NONE;
        end
        if (exp_go && cur_ctrl.s_reg_write && (w[11:7] != 5'd0)) begin
            s_tag[w[11:7]] = (w[6:0] == OP_LOAD) ? TAG_LOAD : TAG_EXEC;
        end
        if (exp_go && cur_ctrl.m_reg_write) begin
            m_tag[w[31:28]] = (w[6:0] == OP_M_LOAD) ? TAG_LOAD : TAG_EXEC;
        end
        if (flush) begin
            exp_out = '0;
        end else if (!freeze && !exp_hazard) begin
            exp_out = exp_next;
        end
        prev_hold = exp_hazard || freeze;
    endtask

    initial begin
        lfsr        = 32'h3b52_3a78;
        nRST        = 1'b0;
        fetch       = '0;
        freeze      = 1'b0;
        flush       = 1'b0;
        fust_s_busy = '0;
        fust_m_busy = 1'b0;
        fust_g_busy = 1'b0;
        wb          = '0;
        errors      = 0;
        checks      = 0;
        new_instr   = 0;
        cycles      = 0;
        prev_hold   = 1'b0;
        exp_out     = '0;
        for (i = 0; i < NUM_SREGS; i++) begin
            s_tag[i] = TAG_NONE;
        end
        for (i = 0; i < NUM_MREGS; i++) begin
            m_tag[i] = TAG_NONE;
        end

        repeat (4) @(negedge CLK);
        nRST = 1'b1;

        while ((new_instr < N_INSTR) && (cycles < MAX_CYCLES)) begin
            @(negedge CLK);
            check_outputs();
            drive_inputs(prev_hold);
            compute_expect();
            advance_model();
            cycles++;
        end
        @(negedge CLK);
        check_outputs();

        if (new_instr < N_INSTR) begin
            errors++;
            $display("timeout after %0d cycles with %0d of %0d instructions fetched",
                     cycles, new_instr, N_INSTR);
        end
        $display("instructions %0d, cycles %0d, checks %0d, errors %0d",
                 new_instr, cycles, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- verilog/dispatch.sv
module dispatch #(
    parameter int NUM_SREGS = dispatch_pkg::NUM_SREGS,
    parameter int NUM_MREGS = dispatch_pkg::NUM_MREGS
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  dispatch_pkg::fetch_t   fetch,
    input  logic                   freeze,
    input  logic                   flush,
    input  logic [2:0]             fust_s_busy,
    input  logic                   fust_m_busy,
    input  logic                   fust_g_busy,
    input  dispatch_pkg::wb_t      wb,
    output dispatch_pkg::dispatch_t out,
    output logic                   stall,
    output logic                   n_fust_s_en,
    output dispatch_pkg::fu_s_e    n_fu_s,
    output dispatch_pkg::fust_s_t  n_fust_s,
    output logic                   n_fust_m_en,
    output dispatch_pkg::fust_m_t  n_fust_m,
    output logic                   n_fust_g_en,
    output dispatch_pkg::fust_g_t  n_fust_g
);

    import dispatch_pkg::*;

    logic [WORD_W-1:0] instr;
    ctrl_t             ctrl;

    sreg_t s_rd;
    sreg_t s_rs1;
    sreg_t s_rs2;
    mreg_t m_rd;
    mreg_t m_rs1;
    mreg_t m_rs2;
    mreg_t m_rs3;

    rst_entry_t [NUM_SREGS-1:0] s_status;
    rst_entry_t [NUM_MREGS-1:0] m_status;

    logic live;
    logic s_busy;
    logic m_busy;
    logic waw;
    logic hazard;
    logic go;

    logic s_di_write;
    tag_t s_di_tag;
    logic m_di_write;
    tag_t m_di_tag;

    dispatch_t next_out;

    // register fields, scalar and matrix formats overlap
    assign instr = fetch.imemload;
    assign s_rd  = instr[11:7];
    assign s_rs1 = instr[19:15];
    assign s_rs2 = instr[24:20];
    assign m_rd  = instr[31:28];
    assign m_rs1 = instr[27:24];
    assign m_rs2 = instr[23:20];
    assign m_rs3 = instr[19:16];

    instr_decoder u_dec (
        .instr (instr),
        .ctrl  (ctrl)
    );

    assign live = fetch.valid && (ctrl.fu_t != FU_NONE_T);

    // structural hazard on the selected unit
    always_comb begin
        case (ctrl.fu_s)
            FU_S_ALU:    s_busy = fust_s_busy[0];
            FU_S_LD_ST:  s_busy = fust_s_busy[1];
            FU_S_BRANCH: s_busy = fust_s_busy[2];
            default:     s_busy = 1'b0;
        endcase

        case (ctrl.fu_m)
            FU_M_LD_ST: m_busy = fust_m_busy;
            FU_M_GEMM:  m_busy = fust_g_busy;
            default:    m_busy = 1'b0;
        endcase
    end

    // waw against the destination's pending write
    always_comb begin
        if (ctrl.s_reg_write) begin
            waw = s_status[s_rd].busy;
        end else if (ctrl.m_reg_write) begin
            waw = m_status[m_rd].busy;
        end else begin
            waw = 1'b0;
        end
    end

    assign hazard = live && (s_busy || m_busy || waw);
    assign stall  = hazard;
    assign go     = live && !hazard && !freeze && !flush;

    // r0 is hardwired, never pending
    assign s_di_write = go && ctrl.s_reg_write && (s_rd != '0);
    assign s_di_tag   = (ctrl.s_mem_type == MEM_LOAD) ? TAG_LOAD : TAG_EXEC;
    assign m_di_write = go && ctrl.m_reg_write;
    assign m_di_tag   = (ctrl.m_mem_type == MEM_LOAD) ? TAG_LOAD : TAG_EXEC;

    reg_status_table #(
        .NREGS (NUM_SREGS)
    ) u_srst (
        .CLK      (CLK),
        .nRST     (nRST),
        .di_write (s_di_write),
        .di_sel   (s_rd),
        .di_tag   (s_di_tag),
        .wb_write (wb.s_rw_en),
        .wb_sel   (wb.s_rw),
        .status   (s_status)
    );

    reg_status_table #(
        .NREGS (NUM_MREGS)
    ) u_mrst (
        .CLK      (CLK),
        .nRST     (nRST),
        .di_write (m_di_write),
        .di_sel   (m_rd),
        .di_tag   (m_di_tag),
        .wb_write (wb.m_rw_en),
        .wb_sel   (wb.m_rw),
        .status   (m_status)
    );

    // issue in the same cycle, cleared entries already read TAG_NONE
    assign n_fust_s_en = go && (ctrl.fu_t == FU_S_T);
    assign n_fust_m_en = go && (ctrl.fu_t == FU_M_T);
    assign n_fust_g_en = go && (ctrl.fu_t == FU_G_T);
    assign n_fu_s      = ctrl.fu_s;

    always_comb begin
        n_fust_s.rd  = s_rd;
        n_fust_s.rs1 = s_rs1;
        n_fust_s.rs2 = s_rs2;
        n_fust_s.imm = ctrl.imm;
        n_fust_s.t1  = s_status[s_rs1].tag;
        n_fust_s.t2  = s_status[s_rs2].tag;

        // matrix ld/st sources are scalar base and stride
        n_fust_m.rd  = m_rd;
        n_fust_m.rs1 = s_rs1;
        n_fust_m.rs2 = s_rs2;
        n_fust_m.imm = ctrl.imm[10:0];
        n_fust_m.t1  = s_status[s_rs1].tag;
        n_fust_m.t2  = s_status[s_rs2].tag;

        n_fust_g.rd  = m_rd;
        n_fust_g.ms1 = m_rs1;
        n_fust_g.ms2 = m_rs2;
        n_fust_g.ms3 = m_rs3;
        n_fust_g.t1  = m_status[m_rs1].tag;
        n_fust_g.t2  = m_status[m_rs2].tag;
        n_fust_g.t3  = m_status[m_rs3].tag;
    end

    always_comb begin
        next_out.valid             = live;
        next_out.fu_s              = ctrl.fu_s;
        next_out.fu_m              = ctrl.fu_m;
        next_out.ex_ctr.imm        = ctrl.imm;
        next_out.ex_ctr.alu_op     = ctrl.alu_op;
        next_out.ex_ctr.branch_op  = ctrl.branch_op;
        next_out.ex_ctr.s_mem_type = ctrl.s_mem_type;
        next_out.ex_ctr.m_mem_type = ctrl.m_mem_type;
        next_out.ex_ctr.m_rw       = m_rd;
        next_out.ex_ctr.m_rw_en    = ctrl.m_reg_write;
        next_out.wb_ctr.s_rw_en    = ctrl.s_reg_write;
        next_out.wb_ctr.s_rw       = s_rd;
    end

    // flush beats freeze, freeze and hazard both hold
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out <= '0;
        end else if (flush) begin
            out <= '0;
        end else if (!freeze && !hazard) begin
            out <= next_out;
        end
    end

endmodule

//--- verilog/dispatch_pkg.sv
package dispatch_pkg;

    // word and register file sizes
    localparam int WORD_W    = 32;
    localparam int NUM_SREGS = 32;
    localparam int NUM_MREGS = 16;

    typedef logic [4:0] sreg_t;
    typedef logic [3:0] mreg_t;
    typedef logic [1:0] tag_t;

    // producer tags, EXEC is the ALU for scalar and GEMM for matrix
    localparam tag_t TAG_NONE = 2'd0;
    localparam tag_t TAG_EXEC = 2'd1;
    localparam tag_t TAG_LOAD = 2'd2;

    // opcodes in bits 6:0
    localparam logic [6:0] OP_ALU_R   = 7'b0110011;
    localparam logic [6:0] OP_ALU_I   = 7'b0010011;
    localparam logic [6:0] OP_LOAD    = 7'b0000011;
    localparam logic [6:0] OP_STORE   = 7'b0100011;
    localparam logic [6:0] OP_BRANCH  = 7'b1100011;
    localparam logic [6:0] OP_M_LOAD  = 7'b0000111;
    localparam logic [6:0] OP_M_STORE = 7'b0100111;
    localparam logic [6:0] OP_GEMM    = 7'b1010111;

    typedef enum logic [1:0] {FU_NONE_T, FU_S_T, FU_M_T, FU_G_T} fu_type_e;

    // values 1 to 3 double as scalar busy vector index plus one
    typedef enum logic [1:0] {FU_S_NONE, FU_S_ALU, FU_S_LD_ST, FU_S_BRANCH} fu_s_e;

    typedef enum logic [1:0] {FU_M_NONE, FU_M_LD_ST, FU_M_GEMM} fu_m_e;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_type_e;

    typedef struct packed {
        fu_type_e   fu_t;
        fu_s_e      fu_s;
        fu_m_e      fu_m;
        logic [11:0] imm;
        logic [2:0] alu_op;
        logic [2:0] branch_op;
        mem_type_e  s_mem_type;
        mem_type_e  m_mem_type;
        logic       s_reg_write;
        logic       m_reg_write;
    } ctrl_t;

    typedef struct packed {
        logic busy;
        tag_t tag;
    } rst_entry_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] imemload;
    } fetch_t;

    // commit notices from writeback
    typedef struct packed {
        logic  s_rw_en;
        sreg_t s_rw;
        logic  m_rw_en;
        mreg_t m_rw;
    } wb_t;

    typedef struct packed {
        sreg_t       rd;
        sreg_t       rs1;
        sreg_t       rs2;
        logic [11:0] imm;
        tag_t        t1;
        tag_t        t2;
    } fust_s_t;

    // rs1 is the base address, rs2 the stride
    typedef struct packed {
        mreg_t       rd;
        sreg_t       rs1;
        sreg_t       rs2;
        logic [10:0] imm;
        tag_t        t1;
        tag_t        t2;
    } fust_m_t;

    typedef struct packed {
        mreg_t rd;
        mreg_t ms1;
        mreg_t ms2;
        mreg_t ms3;
        tag_t  t1;
        tag_t  t2;
        tag_t  t3;
    } fust_g_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [2:0]  alu_op;
        logic [2:0]  branch_op;
        mem_type_e   s_mem_type;
        mem_type_e   m_mem_type;
        mreg_t       m_rw;
        logic        m_rw_en;
    } ex_ctr_t;

    typedef struct packed {
        logic  s_rw_en;
        sreg_t s_rw;
    } wb_ctr_t;

    typedef struct packed {
        logic    valid;
        fu_s_e   fu_s;
        fu_m_e   fu_m;
        ex_ctr_t ex_ctr;
        wb_ctr_t wb_ctr;
    } dispatch_t;

endpackage

//--- verilog/instr_decoder.sv
module instr_decoder (
    input  logic [dispatch_pkg::WORD_W-1:0] instr,
    output dispatch_pkg::ctrl_t             ctrl
);

    import dispatch_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] imm_i;
    logic [11:0] imm_s;
    logic [11:0] imm_b;
    logic [11:0] imm_m;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // immediate formats
    assign imm_i = instr[31:20];
    assign imm_s = {instr[31:25], instr[11:7]};
    // branch offset without the implied zero lsb
    assign imm_b = {instr[31], instr[7], instr[30:25], instr[11:8]};
    // matrix ld/st offset sits around the register fields, 11 bits wide
    assign imm_m = {1'b0, instr[27:25], instr[14:7]};

    always_comb begin
        ctrl = '0;

        case (opcode)
            OP_ALU_R: begin
                ctrl.fu_t        = FU_S_T;
                ctrl.fu_s        = FU_S_ALU;
                ctrl.alu_op      = funct3;
                ctrl.s_reg_write = 1'b1;
            end
            OP_ALU_I: begin
                ctrl.fu_t        = FU_S_T;
                ctrl.fu_s        = FU_S_ALU;
                ctrl.imm         = imm_i;
                ctrl.alu_op      = funct3;
                ctrl.s_reg_write = 1'b1;
            end
            OP_LOAD: begin
                ctrl.fu_t        = FU_S_T;
                ctrl.fu_s        = FU_S_LD_ST;
                ctrl.imm         = imm_i;
                ctrl.alu_op      = funct3;
                ctrl.s_mem_type  = MEM_LOAD;
                ctrl.s_reg_write = 1'b1;
            end
            OP_STORE: begin
                ctrl.fu_t       = FU_S_T;
                ctrl.fu_s       = FU_S_LD_ST;
                ctrl.imm        = imm_s;
                ctrl.alu_op     = funct3;
                ctrl.s_mem_type = MEM_STORE;
            end
            OP_BRANCH: begin
                ctrl.fu_t      = FU_S_T;
                ctrl.fu_s      = FU_S_BRANCH;
                ctrl.imm       = imm_b;
                ctrl.alu_op    = funct3;
                ctrl.branch_op = funct3;
            end
            OP_M_LOAD: begin
                ctrl.fu_t        = FU_M_T;
                ctrl.fu_m        = FU_M_LD_ST;
                ctrl.imm         = imm_m;
                ctrl.alu_op      = funct3;
                ctrl.m_mem_type  = MEM_LOAD;
                ctrl.m_reg_write = 1'b1;
            end
            OP_M_STORE: begin
                ctrl.fu_t       = FU_M_T;
                ctrl.fu_m       = FU_M_LD_ST;
                ctrl.imm        = imm_m;
                ctrl.alu_op     = funct3;
                ctrl.m_mem_type = MEM_STORE;
            end
            OP_GEMM: begin
                ctrl.fu_t        = FU_G_T;
                ctrl.fu_m        = FU_M_GEMM;
                ctrl.alu_op      = funct3;
                ctrl.m_reg_write = 1'b1;
            end
            // illegal opcode leaves everything clear
            default: ctrl = '0;
        endcase
    end

endmodule

//--- verilog/reg_status_table.sv
module reg_status_table #(
    parameter int NREGS = 32
) (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  logic                                   di_write,
    input  logic [$clog2(NREGS)-1:0]               di_sel,
    input  dispatch_pkg::tag_t                     di_tag,
    input  logic                                   wb_write,
    input  logic [$clog2(NREGS)-1:0]               wb_sel,
    output dispatch_pkg::rst_entry_t [NREGS-1:0]   status
);

    import dispatch_pkg::*;

    rst_entry_t [NREGS-1:0] status_next;

    always_comb begin
        status_next = status;

        // commit first so a dispatch to the same register overrides it
        if (wb_write) begin
            status_next[wb_sel].busy = 1'b0;
            status_next[wb_sel].tag  = TAG_NONE;
        end

        if (di_write) begin
            status_next[di_sel].busy = 1'b1;
            status_next[di_sel].tag  = di_tag;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            status <= '0;
        end else begin
            status <= status_next;
        end
    end

endmodule
